//--- common/ex_issue_if.sv
`timescale 1ns/1ps

interface ex_issue_if;

    // qualifies everything below in the same cycle
    logic                      valid;
    ex_pkg::ex_class_e         cls;
    ex_pkg::ex_sel_u           sel;
    logic [ex_pkg::XLEN-1:0]   pc;
    logic [ex_pkg::XLEN-1:0]   imm;
    logic [ex_pkg::XLEN-1:0]   rs1;
    logic [ex_pkg::XLEN-1:0]   rs2;
    logic [ex_pkg::REG_AW-1:0] rd;

    modport src (
        output valid, cls, sel, pc, imm, rs1, rs2, rd
    );

    modport unit (
        input valid, cls, sel, pc, imm, rs1, rs2, rd
    );

endinterface

//--- common/ex_pkg.sv
package ex_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int SHAMT_W = 5;

    // return address distance for jal/jalr
    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

    typedef enum logic [3:0] {
        NOP    = 4'd0,
        LUI    = 4'd1,
        AUIPC  = 4'd2,
        JAL    = 4'd3,
        JALR   = 4'd4,
        BRANCH = 4'd5,
        LOAD   = 4'd6,
        STORE  = 4'd7,
        OP_IMM = 4'd8,
        OP     = 4'd9
    } ex_class_e;

    // funct3 in the low bits, bit 3 marks the alternate form
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_fn_e;

    // same numbering as the branch funct3
    typedef enum logic [3:0] {
        BEQ  = 4'd0,
        BNE  = 4'd1,
        BLT  = 4'd4,
        BGE  = 4'd5,
        BLTU = 4'd6,
        BGEU = 4'd7
    } br_cond_e;

    // stores have bit 3 set
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } mem_kind_e;

    // one select word, read according to the class
    typedef union packed {
        alu_fn_e   alu;
        br_cond_e  br;
        mem_kind_e mem;
    } ex_sel_u;

endpackage

//--- design/agu.sv
`timescale 1ns/1ps

module agu (
    ex_issue_if.unit                iss_i,
    output logic [ex_pkg::XLEN-1:0] addr_o,
    output logic [ex_pkg::XLEN-1:0] wdata_o,
    output logic                    we_o,
    output ex_pkg::mem_kind_e       kind_o
);

    assign addr_o  = iss_i.rs1 + iss_i.imm;
    assign wdata_o = iss_i.rs2;
    assign we_o    = iss_i.cls == ex_pkg::STORE;
    assign kind_o  = iss_i.sel.mem;

    // decode must hand over a kind that matches the direction
    always_comb begin
        if (iss_i.valid && iss_i.cls == ex_pkg::LOAD) begin
            assert (iss_i.sel.mem inside {ex_pkg::LB, ex_pkg::LH, ex_pkg::LW,
                                          ex_pkg::LBU, ex_pkg::LHU})
            else $error("agu: load issued with kind %0d", iss_i.sel.mem);
        end
        if (iss_i.valid && iss_i.cls == ex_pkg::STORE) begin
            assert (iss_i.sel.mem inside {ex_pkg::SB, ex_pkg::SH, ex_pkg::SW})
            else $error("agu: store issued with kind %0d", iss_i.sel.mem);
        end
    end

endmodule

//--- design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    ex_issue_if.unit                iss_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    logic [ex_pkg::XLEN-1:0]    op_b;
    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic                       lt_s;
    logic                       lt_u;
    ex_pkg::alu_fn_e            fn;
    logic [ex_pkg::XLEN-1:0]    alu_res;

    assign op_b  = (iss_i.cls == ex_pkg::OP) ? iss_i.rs2 : iss_i.imm;
    assign shamt = op_b[ex_pkg::SHAMT_W-1:0];

    assign lt_s = $signed(iss_i.rs1) < $signed(op_b);
    assign lt_u = iss_i.rs1 < op_b;

    // no subtract among the immediate forms
    assign fn = (iss_i.cls == ex_pkg::OP_IMM && iss_i.sel.alu == ex_pkg::SUB) ?
                ex_pkg::ADD : iss_i.sel.alu;

    always_comb begin
        case (fn)
            ex_pkg::ADD:  alu_res = iss_i.rs1 + op_b;
            ex_pkg::SUB:  alu_res = iss_i.rs1 - op_b;
            ex_pkg::SLL:  alu_res = iss_i.rs1 << shamt;
            ex_pkg::SLT:  alu_res = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
            ex_pkg::SLTU: alu_res = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
            ex_pkg::XOR:  alu_res = iss_i.rs1 ^ op_b;
            ex_pkg::SRL:  alu_res = iss_i.rs1 >> shamt;
            // sign fill from rs1
            ex_pkg::SRA:  alu_res = $signed(iss_i.rs1) >>> shamt;
            ex_pkg::OR:   alu_res = iss_i.rs1 | op_b;
            ex_pkg::AND:  alu_res = iss_i.rs1 & op_b;
            default:      alu_res = '0;
        endcase
    end

    always_comb begin
        case (iss_i.cls)
            ex_pkg::LUI:    result_o = iss_i.imm;
            ex_pkg::AUIPC:  result_o = iss_i.pc + iss_i.imm;
            ex_pkg::OP,
            ex_pkg::OP_IMM: result_o = alu_res;
            default:        result_o = '0;
        endcase
    end

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    ex_issue_if.unit                iss_i,
    output logic                    taken_o,
    output logic [ex_pkg::XLEN-1:0] target_o,
    output logic [ex_pkg::XLEN-1:0] link_o
);

    logic                    cond;
    logic [ex_pkg::XLEN-1:0] jalr_sum;

    always_comb begin
        case (iss_i.sel.br)
            ex_pkg::BEQ:  cond = iss_i.rs1 == iss_i.rs2;
            ex_pkg::BNE:  cond = iss_i.rs1 != iss_i.rs2;
            ex_pkg::BLT:  cond = $signed(iss_i.rs1) < $signed(iss_i.rs2);
            ex_pkg::BGE:  cond = $signed(iss_i.rs1) >= $signed(iss_i.rs2);
            ex_pkg::BLTU: cond = iss_i.rs1 < iss_i.rs2;
            ex_pkg::BGEU: cond = iss_i.rs1 >= iss_i.rs2;
            // unused funct3 codes never branch
            default:      cond = 1'b0;
        endcase
    end

    always_comb begin
        case (iss_i.cls)
            ex_pkg::JAL,
            ex_pkg::JALR:   taken_o = 1'b1;
            ex_pkg::BRANCH: taken_o = cond;
            default:        taken_o = 1'b0;
        endcase
    end

    assign jalr_sum = iss_i.rs1 + iss_i.imm;

    // jalr target has bit 0 forced low
    assign target_o = (iss_i.cls == ex_pkg::JALR) ?
                      {jalr_sum[ex_pkg::XLEN-1:1], 1'b0} : iss_i.pc + iss_i.imm;

    assign link_o = iss_i.pc + ex_pkg::LINK_OFFSET;

endmodule

//--- design/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    ex_issue_if.unit                  iss_i,
    input  logic [ex_pkg::XLEN-1:0]   alu_i,
    input  logic                      taken_i,
    input  logic [ex_pkg::XLEN-1:0]   target_i,
    input  logic [ex_pkg::XLEN-1:0]   link_i,
    input  logic [ex_pkg::XLEN-1:0]   addr_i,
    input  logic [ex_pkg::XLEN-1:0]   wdata_i,
    input  logic                      we_i,
    input  ex_pkg::mem_kind_e         kind_i,

    output logic                      rd_we_o,
    output logic [ex_pkg::REG_AW-1:0] rd_o,
    output logic [ex_pkg::XLEN-1:0]   rd_data_o,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output ex_pkg::mem_kind_e         mem_kind_o,
    output logic [ex_pkg::XLEN-1:0]   mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]   mem_wdata_o,
    output logic                      redirect_o,
    output logic [ex_pkg::XLEN-1:0]   redirect_pc_o
);

    logic                    writes_rd;
    logic                    rd_we_d;
    logic                    mem_req_d;
    logic                    redirect_d;
    logic [ex_pkg::XLEN-1:0] wr_data_d;

    always_comb begin
        case (iss_i.cls)
            ex_pkg::LUI, ex_pkg::AUIPC, ex_pkg::JAL, ex_pkg::JALR,
            ex_pkg::OP, ex_pkg::OP_IMM, ex_pkg::LOAD: writes_rd = 1'b1;
            default:                                  writes_rd = 1'b0;
        endcase
    end

    // x0 is never written
    assign rd_we_d    = iss_i.valid && writes_rd && (iss_i.rd != '0);
    assign mem_req_d  = iss_i.valid && (iss_i.cls == ex_pkg::LOAD || iss_i.cls == ex_pkg::STORE);
    assign redirect_d = iss_i.valid && taken_i;

    // load data comes back later from memory
    always_comb begin
        case (iss_i.cls)
            ex_pkg::JAL,
            ex_pkg::JALR: wr_data_d = link_i;
            ex_pkg::LOAD: wr_data_d = '0;
            default:      wr_data_d = alu_i;
        endcase
    end

    // payload is zeroed whenever its strobe is low
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_we_o       <= 1'b0;
            rd_o          <= '0;
            rd_data_o     <= '0;
            mem_req_o     <= 1'b0;
            mem_we_o      <= 1'b0;
            mem_kind_o    <= ex_pkg::mem_kind_e'(4'd0);
            mem_addr_o    <= '0;
            mem_wdata_o   <= '0;
            redirect_o    <= 1'b0;
            redirect_pc_o <= '0;
        end else begin
            rd_we_o       <= rd_we_d;
            rd_o          <= rd_we_d ? iss_i.rd : '0;
            rd_data_o     <= rd_we_d ? wr_data_d : '0;
            mem_req_o     <= mem_req_d;
            mem_we_o      <= mem_req_d && we_i;
            mem_kind_o    <= mem_req_d ? kind_i : ex_pkg::mem_kind_e'(4'd0);
            mem_addr_o    <= mem_req_d ? addr_i : '0;
            mem_wdata_o   <= (mem_req_d && we_i) ? wdata_i : '0;
            redirect_o    <= redirect_d;
            redirect_pc_o <= redirect_d ? target_i : '0;
        end
    end

    // taken only comes from jump and branch classes
    a_no_redirect_with_mem: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(redirect_o && mem_req_o)
    ) else $error("ex_mem_reg: redirect and memory request together");

    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) rd_we_o |-> (rd_o != '0)
    ) else $error("ex_mem_reg: write enable with rd zero");

    a_idle_after_invalid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !iss_i.valid |=> !(rd_we_o || mem_req_o || redirect_o)
    ) else $error("ex_mem_reg: strobe raised after an invalid cycle");

endmodule

//--- design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  ex_pkg::ex_class_e         cls_i,
    input  ex_pkg::ex_sel_u           sel_i,
    input  logic [ex_pkg::XLEN-1:0]   pc_i,
    input  logic [ex_pkg::XLEN-1:0]   imm_i,
    input  logic [ex_pkg::XLEN-1:0]   rs1_i,
    input  logic [ex_pkg::XLEN-1:0]   rs2_i,
    input  logic [ex_pkg::REG_AW-1:0] rd_i,

    output logic                      rd_we_o,
    output logic [ex_pkg::REG_AW-1:0] rd_o,
    output logic [ex_pkg::XLEN-1:0]   rd_data_o,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output ex_pkg::mem_kind_e         mem_kind_o,
    output logic [ex_pkg::XLEN-1:0]   mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]   mem_wdata_o,
    output logic                      redirect_o,
    output logic [ex_pkg::XLEN-1:0]   redirect_pc_o
);

    logic [ex_pkg::XLEN-1:0] alu_res;
    logic                    br_taken;
    logic [ex_pkg::XLEN-1:0] br_target;
    logic [ex_pkg::XLEN-1:0] br_link;
    logic [ex_pkg::XLEN-1:0] agu_addr;
    logic [ex_pkg::XLEN-1:0] agu_wdata;
    logic                    agu_we;
    ex_pkg::mem_kind_e       agu_kind;

    ex_issue_if iss ();

    // issue side of the bundle
    assign iss.valid = valid_i;
    assign iss.cls   = cls_i;
    assign iss.sel   = sel_i;
    assign iss.pc    = pc_i;
    assign iss.imm   = imm_i;
    assign iss.rs1   = rs1_i;
    assign iss.rs2   = rs2_i;
    assign iss.rd    = rd_i;

    alu_unit u_alu (
        .iss_i    (iss),
        .result_o (alu_res)
    );

    branch_unit u_branch (
        .iss_i    (iss),
        .taken_o  (br_taken),
        .target_o (br_target),
        .link_o   (br_link)
    );

    agu u_agu (
        .iss_i   (iss),
        .addr_o  (agu_addr),
        .wdata_o (agu_wdata),
        .we_o    (agu_we),
        .kind_o  (agu_kind)
    );

    ex_mem_reg u_ex_mem (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .iss_i         (iss),
        .alu_i         (alu_res),
        .taken_i       (br_taken),
        .target_i      (br_target),
        .link_i        (br_link),
        .addr_i        (agu_addr),
        .wdata_i       (agu_wdata),
        .we_i          (agu_we),
        .kind_i        (agu_kind),
        .rd_we_o       (rd_we_o),
        .rd_o          (rd_o),
        .rd_data_o     (rd_data_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_kind_o    (mem_kind_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_ex_stage -o tb_ex_stage
out=$(./obj_dir/tb_ex_stage || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Done: no errors$"

//--- tests/ex_checker.sv
`timescale 1ns/1ps

module ex_checker (
    input  logic                      clk_i,
    input  logic                      chk_en_i,
    input  logic [95:0]               name_i,
    input  logic [140:0]              exp_i,
    input  logic                      rd_we_i,
    input  logic [ex_pkg::REG_AW-1:0] rd_i,
    input  logic [ex_pkg::XLEN-1:0]   rd_data_i,
    input  logic                      mem_req_i,
    input  logic                      mem_we_i,
    input  ex_pkg::mem_kind_e         mem_kind_i,
    input  logic [ex_pkg::XLEN-1:0]   mem_addr_i,
    input  logic [ex_pkg::XLEN-1:0]   mem_wdata_i,
    input  logic                      redirect_i,
    input  logic [ex_pkg::XLEN-1:0]   redirect_pc_i,
    output int                        pass_cnt_o,
    output int                        fail_cnt_o
);

    logic         pend = 1'b0;
    logic [95:0]  pend_name;
    logic [140:0] pend_exp;
    logic [140:0] act;
    int           n_pass = 0;
    int           n_fail = 0;

    // same field order as the expected vector
    assign act = {rd_we_i, rd_i, rd_data_i, mem_req_i, mem_we_i, mem_kind_i,
                  mem_addr_i, mem_wdata_i, redirect_i, redirect_pc_i};

    assign pass_cnt_o = n_pass;
    assign fail_cnt_o = n_fail;

    // an issue registered at one edge is read back at the next one
    always @(posedge clk_i) begin
        if (pend) begin
            if (act !== pend_exp) begin
                n_fail <= n_fail + 1;
                $display("ERROR %s: expected %h, actual %h", pend_name, pend_exp, act);
            end else begin
                n_pass <= n_pass + 1;
                $display("ok    %s", pend_name);
            end
        end
        pend      <= chk_en_i;
        pend_name <= name_i;
        pend_exp  <= exp_i;
    end

endmodule

//--- tests/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    localparam int RST_CYCLES = 5;
    localparam int WAIT_MAX   = 10;
    localparam logic [39:0] RAND_FNS = {ex_pkg::ADD, ex_pkg::SUB, ex_pkg::SLL, ex_pkg::SLT,
                                        ex_pkg::SLTU, ex_pkg::XOR, ex_pkg::SRL, ex_pkg::SRA,
                                        ex_pkg::OR, ex_pkg::AND};

    typedef struct packed {
        logic              valid;
        ex_pkg::ex_class_e cls;
        logic [3:0]        sel;
        logic [31:0]       pc;
        logic [31:0]       imm;
        logic [31:0]       rs1;
        logic [31:0]       rs2;
        logic [4:0]        rd;
    } row_t;

    logic              clk_i;
    logic              rst_n_i;
    logic              valid_i;
    ex_pkg::ex_class_e cls_i;
    ex_pkg::ex_sel_u   sel_i;
    logic [31:0]       pc_i, imm_i, rs1_i, rs2_i;
    logic [4:0]        rd_i;
    logic              rd_we_o, mem_req_o, mem_we_o, redirect_o;
    logic [4:0]        rd_o;
    logic [31:0]       rd_data_o, mem_addr_o, mem_wdata_o, redirect_pc_o;
    ex_pkg::mem_kind_e mem_kind_o;
    logic              chk_en;
    logic [95:0]       chk_name;
    logic [140:0]      chk_exp;
    int                pass_cnt;
    int                fail_cnt;
    row_t              rows [$];
    logic [95:0]       names [$];
    logic [31:0]       lfsr = 32'hacf;

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ex_stage dut_i (.*);

    ex_checker chk_i (
        .clk_i         (clk_i),
        .chk_en_i      (chk_en),
        .name_i        (chk_name),
        .exp_i         (chk_exp),
        .rd_we_i       (rd_we_o),
        .rd_i          (rd_o),
        .rd_data_i     (rd_data_o),
        .mem_req_i     (mem_req_o),
        .mem_we_i      (mem_we_o),
        .mem_kind_i    (mem_kind_o),
        .mem_addr_i    (mem_addr_o),
        .mem_wdata_i   (mem_wdata_o),
        .redirect_i    (redirect_o),
        .redirect_pc_i (redirect_pc_o),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int n = 0; n < 32; n++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    // {rd_we, rd, rd_data, mem_req, mem_we, kind, mem_addr, mem_wdata, redirect, redirect_pc}
    function automatic logic [140:0] predict(input row_t r);
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] tgt;
        logic        wb;
        logic        mem;
        logic        st;
        logic        tk;
        if (!r.valid || r.cls == ex_pkg::NOP)
            return '0;
        b = (r.cls == ex_pkg::OP) ? r.rs2 : r.imm;
        case (r.sel)
            ex_pkg::ADD:  res = r.rs1 + b;
            ex_pkg::SUB:  res = (r.cls == ex_pkg::OP) ? r.rs1 - b : r.rs1 + b;
            ex_pkg::SLL:  res = r.rs1 << b[4:0];
            ex_pkg::SLT:  res = {31'd0, $signed(r.rs1) < $signed(b)};
            ex_pkg::SLTU: res = {31'd0, r.rs1 < b};
            ex_pkg::XOR:  res = r.rs1 ^ b;
            ex_pkg::SRL:  res = r.rs1 >> b[4:0];
            ex_pkg::SRA:  res = $signed(r.rs1) >>> b[4:0];
            ex_pkg::OR:   res = r.rs1 | b;
            ex_pkg::AND:  res = r.rs1 & b;
            default:      res = '0;
        endcase
        if (r.cls == ex_pkg::LUI)
            res = r.imm;
        else if (r.cls == ex_pkg::AUIPC)
            res = r.pc + r.imm;
        else if (r.cls inside {ex_pkg::JAL, ex_pkg::JALR})
            res = r.pc + 32'd4;
        else if (r.cls == ex_pkg::LOAD)
            res = '0;
        case (r.sel)
            ex_pkg::BEQ:  tk = r.rs1 == r.rs2;
            ex_pkg::BNE:  tk = r.rs1 != r.rs2;
            ex_pkg::BLT:  tk = $signed(r.rs1) < $signed(r.rs2);
            ex_pkg::BGE:  tk = !($signed(r.rs1) < $signed(r.rs2));
            ex_pkg::BLTU: tk = r.rs1 < r.rs2;
            ex_pkg::BGEU: tk = !(r.rs1 < r.rs2);
            default:      tk = 1'b0;
        endcase
        tk  = (r.cls == ex_pkg::BRANCH) ? tk : r.cls inside {ex_pkg::JAL, ex_pkg::JALR};
        tgt = (r.cls == ex_pkg::JALR) ? (r.rs1 + r.imm) & ~32'd1 : r.pc + r.imm;
        wb  = r.cls inside {ex_pkg::LUI, ex_pkg::AUIPC, ex_pkg::JAL, ex_pkg::JALR,
                            ex_pkg::OP, ex_pkg::OP_IMM, ex_pkg::LOAD};
        wb  = wb && r.rd != 5'd0;
        mem = r.cls inside {ex_pkg::LOAD, ex_pkg::STORE};
        st  = r.cls == ex_pkg::STORE;
        return {wb, wb ? r.rd : 5'd0, wb ? res : 32'd0, mem, st, mem ? r.sel : 4'd0,
                mem ? r.rs1 + r.imm : 32'd0, st ? r.rs2 : 32'd0, tk, tk ? tgt : 32'd0};
    endfunction

    task automatic add_row(input logic [95:0] name, input logic v, input ex_pkg::ex_class_e c,
                           input logic [3:0] s, input logic [31:0] pc, input logic [31:0] imm,
                           input logic [31:0] a, input logic [31:0] b, input logic [4:0] rd);
        names.push_back(name);
        rows.push_back(row_t'{v, c, s, pc, imm, a, b, rd});
    endtask

    task automatic op_row(input logic [95:0] name, input logic [3:0] s, input logic [31:0] a,
                          input logic [31:0] b, input logic [4:0] rd);
        add_row(name, 1'b1, ex_pkg::OP, s, 32'h0, 32'h0, a, b, rd);
    endtask

    task automatic imm_row(input logic [95:0] name, input logic [3:0] s, input logic [31:0] a,
                           input logic [31:0] imm, input logic [4:0] rd);
        add_row(name, 1'b1, ex_pkg::OP_IMM, s, 32'h0, imm, a, 32'h0, rd);
    endtask

    // nonzero rd, so a branch that writes would show up
    task automatic br_row(input logic [95:0] name, input logic [3:0] s, input logic [31:0] a,
                          input logic [31:0] b);
        add_row(name, 1'b1, ex_pkg::BRANCH, s, 32'h300, 32'hffff_fff0, a, b, 5'd5);
    endtask

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        int          waited;
        rst_n_i  = 1'b0;
        valid_i  = 1'b0;
        cls_i    = ex_pkg::NOP;
        sel_i    = '0;
        pc_i     = '0;
        imm_i    = '0;
        rs1_i    = '0;
        rs2_i    = '0;
        rd_i     = '0;
        chk_en   = 1'b0;
        chk_name = '0;
        chk_exp  = '0;
        // name, valid, class, select, pc, imm, rs1, rs2, rd
        for (int i = 0; i < RST_CYCLES - 1; i++)
            op_row("reset", ex_pkg::ADD, 32'h1, 32'h2, 5'd1);
        add_row("idle", 1'b0, ex_pkg::OP, ex_pkg::ADD, 32'h0, 32'h0, 32'h1, 32'h2, 5'd1);
        op_row("add", ex_pkg::ADD, 32'h7fff_ffff, 32'h1, 5'd1);
        op_row("sub", ex_pkg::SUB, 32'h0, 32'h1, 5'd2);
        op_row("sll", ex_pkg::SLL, 32'h8000_0001, 32'hffff_ffe3, 5'd3);
        op_row("slt", ex_pkg::SLT, 32'hffff_fffe, 32'h1, 5'd4);
        op_row("sltu", ex_pkg::SLTU, 32'hffff_fffe, 32'h1, 5'd5);
        op_row("xor", ex_pkg::XOR, 32'h0f0f_00ff, 32'hff00_0ff0, 5'd6);
        op_row("srl", ex_pkg::SRL, 32'h8000_0000, 32'h0000_003f, 5'd7);
        op_row("sra", ex_pkg::SRA, 32'h8000_0000, 32'h0000_0024, 5'd8);
        op_row("or", ex_pkg::OR, 32'h1200_0034, 32'h0056_7800, 5'd9);
        op_row("and", ex_pkg::AND, 32'hf0f0_ffff, 32'h0ff0_1234, 5'd10);
        imm_row("addi", ex_pkg::ADD, 32'h10, 32'hffff_f800, 5'd11);
        imm_row("slti", ex_pkg::SLT, 32'h8000_0000, 32'hffff_ffff, 5'd12);
        imm_row("sltiu", ex_pkg::SLTU, 32'h5, 32'hffff_ffff, 5'd13);
        imm_row("slli", ex_pkg::SLL, 32'h1, 32'h0000_001f, 5'd14);
        imm_row("srai", ex_pkg::SRA, 32'h8765_4321, 32'h0000_0408, 5'd15);
        imm_row("xori", ex_pkg::XOR, 32'h00ff_00ff, 32'hffff_f0f0, 5'd16);
        imm_row("srli", ex_pkg::SRL, 32'h8000_0010, 32'h0000_0404, 5'd17);
        imm_row("ori", ex_pkg::OR, 32'h1200_0000, 32'h0000_0345, 5'd18);
        imm_row("andi", ex_pkg::AND, 32'hdead_beef, 32'hffff_ff0f, 5'd19);
        add_row("lui", 1'b1, ex_pkg::LUI, 4'h0, 32'h0, 32'h1234_5000, 32'h0, 32'h0, 5'd9);
        add_row("auipc", 1'b1, ex_pkg::AUIPC, 4'h0, 32'h1000, 32'h2000_0000, 32'h0, 32'h0, 5'd9);
        add_row("jal", 1'b1, ex_pkg::JAL, 4'h0, 32'h100, 32'h40, 32'h0, 32'h0, 5'd1);
        add_row("jalr", 1'b1, ex_pkg::JALR, 4'h0, 32'h200, 32'h7, 32'h1000, 32'h0, 5'd1);
        br_row("beq_t", ex_pkg::BEQ, 32'h5, 32'h5);
        br_row("beq_nt", ex_pkg::BEQ, 32'h5, 32'h6);
        br_row("bne_t", ex_pkg::BNE, 32'h1, 32'h2);
        br_row("bne_nt", ex_pkg::BNE, 32'h3, 32'h3);
        br_row("blt_t", ex_pkg::BLT, 32'hffff_ffff, 32'h1);
        br_row("blt_nt", ex_pkg::BLT, 32'h1, 32'hffff_ffff);
        br_row("bge_t", ex_pkg::BGE, 32'h1, 32'hffff_ffff);
        br_row("bge_nt", ex_pkg::BGE, 32'hffff_ffff, 32'h1);
        br_row("bltu_t", ex_pkg::BLTU, 32'h1, 32'hffff_ffff);
        br_row("bltu_nt", ex_pkg::BLTU, 32'hffff_ffff, 32'h1);
        br_row("bgeu_t", ex_pkg::BGEU, 32'hffff_ffff, 32'h1);
        br_row("bgeu_nt", ex_pkg::BGEU, 32'h1, 32'hffff_ffff);
        add_row("lw", 1'b1, ex_pkg::LOAD, ex_pkg::LW, 32'h0, 32'hffff_fffc, 32'h1000, 32'h0, 5'd12);
        add_row("lbu", 1'b1, ex_pkg::LOAD, ex_pkg::LBU, 32'h0, 32'h3, 32'h2000, 32'h0, 5'd13);
        add_row("sw", 1'b1, ex_pkg::STORE, ex_pkg::SW, 32'h0, 32'h8, 32'h1000, 32'hdead_beef, 5'd0);
        add_row("sb", 1'b1, ex_pkg::STORE, ex_pkg::SB, 32'h0, 32'h1, 32'h1000, 32'h55, 5'd7);
        op_row("add_x0", ex_pkg::ADD, 32'h1, 32'h2, 5'd0);
        add_row("lui_x0", 1'b1, ex_pkg::LUI, 4'h0, 32'h0, 32'hfff0_0000, 32'h0, 32'h0, 5'd0);
        add_row("nop", 1'b1, ex_pkg::NOP, 4'h0, 32'h40, 32'h4, 32'h1, 32'h2, 5'd3);
        for (int k = 0; k < 10; k++) begin
            ra = rand_word();
            rb = rand_word();
            op_row("rand_op", RAND_FNS[4*k +: 4], ra, rb, 5'd16 + 5'(k));
        end

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk_i);
            if (i == RST_CYCLES - 1)
                rst_n_i = 1'b1;
            valid_i  = rows[i].valid;
            cls_i    = rows[i].cls;
            sel_i    = rows[i].sel;
            pc_i     = rows[i].pc;
            imm_i    = rows[i].imm;
            rs1_i    = rows[i].rs1;
            rs2_i    = rows[i].rs2;
            rd_i     = rows[i].rd;
            chk_en   = 1'b1;
            chk_name = names[i];
            // still in reset when these are registered
            chk_exp  = (i < RST_CYCLES - 1) ? '0 : predict(rows[i]);
        end
        @(negedge clk_i);
        valid_i = 1'b0;
        chk_en  = 1'b0;

        waited = 0;
        while (pass_cnt + fail_cnt < rows.size() && waited < WAIT_MAX) begin
            @(negedge clk_i);
            waited++;
        end
        $display("tests %0d, passed %0d, failed %0d", rows.size(), pass_cnt, fail_cnt);
        if (pass_cnt + fail_cnt < rows.size())
            $display("timeout: the checker did not report a result for every test");
        if (fail_cnt == 0 && pass_cnt == rows.size())
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- vlog.f
common/ex_pkg.sv
common/ex_issue_if.sv
design/alu_unit.sv
design/branch_unit.sv
design/agu.sv
design/ex_mem_reg.sv
design/ex_stage.sv
tests/ex_checker.sv
tests/tb_ex_stage.sv
